// File: compile.f
logic/core_pkg.sv
logic/regfile.sv
logic/issue_unit.sv
logic/exec_lane.sv
logic/writeback_unit.sv
logic/core_top.sv
test/core_tb.sv

// File: logic/core_pkg.sv
package core_pkg;

	localparam int WORD_W = 32;
	localparam int REG_AW = 5;
	localparam int ISSUE_NUM = 2;
	localparam int REG_NUM = 32;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WORD_W-1:0] instr_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADDU,
		ALU_SUBU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_ADDIU,
		ALU_ORI,
		ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		ACK_WAIT
	} issue_state_t;

	// instruction fields
	localparam int OPC_MSB = 31;
	localparam int OPC_LSB = 26;
	localparam int RS_MSB = 25;
	localparam int RS_LSB = 21;
	localparam int RT_MSB = 20;
	localparam int RT_LSB = 16;
	localparam int RD_MSB = 15;
	localparam int RD_LSB = 11;
	localparam int SA_MSB = 10;
	localparam int SA_LSB = 6;
	localparam int FN_MSB = 5;
	localparam int FN_LSB = 0;
	localparam int IMM_MSB = 15;
	localparam int IMM_LSB = 0;

	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_ORI = 6'h0d;
	localparam logic [5:0] OPC_LUI = 6'h0f;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

endpackage

// File: logic/core_top.sv
`timescale 1ns/100ps

module core_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                bundle_req,
	input  core_pkg::instr_t    bundle_instr0,
	input  core_pkg::instr_t    bundle_instr1,
	output logic                bundle_ack,
	input  core_pkg::reg_addr_t dbg_addr,
	output core_pkg::word_t     dbg_data,
	output core_pkg::word_t     retire_count
);

import core_pkg::*;

// issue to lanes
logic [ISSUE_NUM-1:0] lane_valid;
alu_op_t [ISSUE_NUM-1:0] lane_op;
word_t [ISSUE_NUM-1:0] lane_a;
word_t [ISSUE_NUM-1:0] lane_b;
reg_addr_t [ISSUE_NUM-1:0] lane_rd;

// lane results, also the bypass source
logic [ISSUE_NUM-1:0] res_valid;
reg_addr_t [ISSUE_NUM-1:0] res_rd;
word_t [ISSUE_NUM-1:0] res_data;

logic [ISSUE_NUM-1:0] rf_we;
reg_addr_t [ISSUE_NUM-1:0] rf_waddr;
word_t [ISSUE_NUM-1:0] rf_wdata;
reg_addr_t [2*ISSUE_NUM-1:0] issue_raddr;
// debug port sits above the issue read ports
reg_addr_t [2*ISSUE_NUM:0] rf_raddr;
word_t [2*ISSUE_NUM:0] rf_rdata;

assign rf_raddr = {dbg_addr, issue_raddr};
assign dbg_data = rf_rdata[2*ISSUE_NUM];

issue_unit i_issue_unit (
	.clk,
	.rst,
	.bundle_req,
	.bundle_instr0,
	.bundle_instr1,
	.bundle_ack,
	.raddr      ( issue_raddr                 ),
	.rdata      ( rf_rdata[2*ISSUE_NUM-1:0]   ),
	.res_valid,
	.res_rd,
	.res_data,
	.lane_valid,
	.lane_op,
	.lane_a,
	.lane_b,
	.lane_rd
);

for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_lane
	exec_lane i_exec_lane (
		.clk,
		.rst,
		.lane_valid ( lane_valid[i] ),
		.lane_op    ( lane_op[i]    ),
		.lane_a     ( lane_a[i]     ),
		.lane_b     ( lane_b[i]     ),
		.lane_rd    ( lane_rd[i]    ),
		.res_valid  ( res_valid[i]  ),
		.res_rd     ( res_rd[i]     ),
		.res_data   ( res_data[i]   )
	);
end

writeback_unit i_writeback_unit (
	.clk,
	.rst,
	.res_valid,
	.res_rd,
	.res_data,
	.we    ( rf_we    ),
	.waddr ( rf_waddr ),
	.wdata ( rf_wdata ),
	.retire_count
);

regfile #(
	.READ_PORTS ( 2*ISSUE_NUM+1 )
) i_regfile (
	.clk,
	.rst,
	.we    ( rf_we    ),
	.waddr ( rf_waddr ),
	.wdata ( rf_wdata ),
	.raddr ( rf_raddr ),
	.rdata ( rf_rdata )
);

endmodule

// File: logic/exec_lane.sv
`timescale 1ns/100ps

module exec_lane (
	input  logic                clk,
	input  logic                rst,
	input  logic                lane_valid,
	input  core_pkg::alu_op_t   lane_op,
	input  core_pkg::word_t     lane_a,
	input  core_pkg::word_t     lane_b,
	input  core_pkg::reg_addr_t lane_rd,
	output logic                res_valid,
	output core_pkg::reg_addr_t res_rd,
	output core_pkg::word_t     res_data
);

import core_pkg::*;

word_t alu_out;
reg_addr_t dest;

always_comb begin
	case (lane_op)
		ALU_ADDU,
		ALU_ADDIU: begin
			alu_out = lane_a + lane_b;
		end
		ALU_SUBU: begin
			alu_out = lane_a - lane_b;
		end
		ALU_AND: begin
			alu_out = lane_a & lane_b;
		end
		ALU_OR,
		ALU_ORI: begin
			alu_out = lane_a | lane_b;
		end
		ALU_XOR: begin
			alu_out = lane_a ^ lane_b;
		end
		ALU_SLT: begin
			alu_out = word_t'($signed(lane_a) < $signed(lane_b));
		end
		ALU_SLL: begin
			alu_out = lane_b << lane_a[4:0];
		end
		ALU_LUI: begin
			// upper immediate already formed in issue
			alu_out = lane_b;
		end
		default: begin
			alu_out = '0;
		end
	endcase
end

// no-op still retires, aimed at r0
assign dest = (lane_op == ALU_NOP) ? '0 : lane_rd;

always_ff @(posedge clk) begin
	if (rst) begin
		res_valid <= 1'b0;
	end else begin
		res_valid <= lane_valid;
	end
end

always_ff @(posedge clk) begin
	res_rd <= dest;
	res_data <= alu_out;
end

endmodule

// File: logic/issue_unit.sv
`timescale 1ns/100ps

module issue_unit (
	input  logic                                             clk,
	input  logic                                             rst,
	input  logic                                             bundle_req,
	input  core_pkg::instr_t                                 bundle_instr0,
	input  core_pkg::instr_t                                 bundle_instr1,
	output logic                                             bundle_ack,
	output core_pkg::reg_addr_t [2*core_pkg::ISSUE_NUM-1:0]  raddr,
	input  core_pkg::word_t [2*core_pkg::ISSUE_NUM-1:0]      rdata,
	input  logic [core_pkg::ISSUE_NUM-1:0]                   res_valid,
	input  core_pkg::reg_addr_t [core_pkg::ISSUE_NUM-1:0]    res_rd,
	input  core_pkg::word_t [core_pkg::ISSUE_NUM-1:0]        res_data,
	output logic [core_pkg::ISSUE_NUM-1:0]                   lane_valid,
	output core_pkg::alu_op_t [core_pkg::ISSUE_NUM-1:0]      lane_op,
	output core_pkg::word_t [core_pkg::ISSUE_NUM-1:0]        lane_a,
	output core_pkg::word_t [core_pkg::ISSUE_NUM-1:0]        lane_b,
	output core_pkg::reg_addr_t [core_pkg::ISSUE_NUM-1:0]    lane_rd
);

import core_pkg::*;

issue_state_t state;
instr_t [ISSUE_NUM-1:0] slot_instr;
logic [ISSUE_NUM-1:0] pending;
logic [ISSUE_NUM-1:0] go;
logic [ISSUE_NUM-1:0] stall;
logic [ISSUE_NUM-1:0] a_is_reg;
logic [ISSUE_NUM-1:0] b_is_reg;
alu_op_t [ISSUE_NUM-1:0] dec_op;
reg_addr_t [ISSUE_NUM-1:0] dec_rs;
reg_addr_t [ISSUE_NUM-1:0] dec_rt;
reg_addr_t [ISSUE_NUM-1:0] dec_rd;
word_t [ISSUE_NUM-1:0] imm_a;
word_t [ISSUE_NUM-1:0] imm_b;
word_t [ISSUE_NUM-1:0] opnd_a;
word_t [ISSUE_NUM-1:0] opnd_b;
logic dep_10;

// dispatched last cycle, result not in a lane register yet
function automatic logic in_flight(input reg_addr_t src);
	logic hit;
	hit = 1'b0;
	for (int j = 0; j < ISSUE_NUM; j++) begin
		if (lane_valid[j] && lane_rd[j] == src && src != '0) begin
			hit = 1'b1;
		end
	end
	return hit;
endfunction

// later lane wins, it holds the younger slot
function automatic word_t bypass(input reg_addr_t src, input word_t rf_val);
	word_t val;
	val = rf_val;
	for (int j = 0; j < ISSUE_NUM; j++) begin
		if (res_valid[j] && res_rd[j] == src && src != '0) begin
			val = res_data[j];
		end
	end
	return val;
endfunction

always_comb begin
	for (int s = 0; s < ISSUE_NUM; s++) begin
		dec_rs[s] = slot_instr[s][RS_MSB:RS_LSB];
		dec_rt[s] = slot_instr[s][RT_MSB:RT_LSB];
		dec_op[s] = ALU_NOP;
		dec_rd[s] = '0;
		a_is_reg[s] = 1'b0;
		b_is_reg[s] = 1'b0;
		imm_a[s] = word_t'(slot_instr[s][SA_MSB:SA_LSB]);
		imm_b[s] = '0;
		case (slot_instr[s][OPC_MSB:OPC_LSB])
			OPC_SPECIAL: begin
				a_is_reg[s] = 1'b1;
				b_is_reg[s] = 1'b1;
				dec_rd[s] = slot_instr[s][RD_MSB:RD_LSB];
				case (slot_instr[s][FN_MSB:FN_LSB])
					FN_ADDU: dec_op[s] = ALU_ADDU;
					FN_SUBU: dec_op[s] = ALU_SUBU;
					FN_AND: dec_op[s] = ALU_AND;
					FN_OR: dec_op[s] = ALU_OR;
					FN_XOR: dec_op[s] = ALU_XOR;
					FN_SLT: dec_op[s] = ALU_SLT;
					FN_SLL: begin
						// shift amount rides on operand a
						dec_op[s] = ALU_SLL;
						a_is_reg[s] = 1'b0;
					end
					default: begin
						a_is_reg[s] = 1'b0;
						b_is_reg[s] = 1'b0;
						dec_rd[s] = '0;
					end
				endcase
			end
			OPC_ADDIU: begin
				dec_op[s] = ALU_ADDIU;
				a_is_reg[s] = 1'b1;
				dec_rd[s] = dec_rt[s];
				imm_b[s] = {{(WORD_W-16){slot_instr[s][IMM_MSB]}}, slot_instr[s][IMM_MSB:IMM_LSB]};
			end
			OPC_ORI: begin
				dec_op[s] = ALU_ORI;
				a_is_reg[s] = 1'b1;
				dec_rd[s] = dec_rt[s];
				imm_b[s] = word_t'(slot_instr[s][IMM_MSB:IMM_LSB]);
			end
			OPC_LUI: begin
				dec_op[s] = ALU_LUI;
				dec_rd[s] = dec_rt[s];
				imm_b[s] = {slot_instr[s][IMM_MSB:IMM_LSB], 16'h0000};
			end
			default: ;
		endcase
	end
end

always_comb begin
	for (int s = 0; s < ISSUE_NUM; s++) begin
		raddr[2*s] = dec_rs[s];
		raddr[2*s+1] = dec_rt[s];
		opnd_a[s] = a_is_reg[s] ? bypass(dec_rs[s], rdata[2*s]) : imm_a[s];
		opnd_b[s] = b_is_reg[s] ? bypass(dec_rt[s], rdata[2*s+1]) : imm_b[s];
		stall[s] = (a_is_reg[s] && in_flight(dec_rs[s])) ||
			(b_is_reg[s] && in_flight(dec_rt[s]));
	end
end

// slot 1 reads what slot 0 writes
assign dep_10 = dec_rd[0] != '0 &&
	((a_is_reg[1] && dec_rs[1] == dec_rd[0]) || (b_is_reg[1] && dec_rt[1] == dec_rd[0]));

// in order, slot 1 never passes slot 0
always_comb begin
	go = '0;
	if (state == ISSUE) begin
		go[0] = pending[0] && !stall[0];
		go[1] = pending[1] && !stall[1] && (!pending[0] || (go[0] && !dep_10));
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		state <= IDLE;
		pending <= '0;
		bundle_ack <= 1'b0;
		lane_valid <= '0;
	end else begin
		lane_valid <= go;
		case (state)
			IDLE: begin
				if (bundle_req) begin
					state <= ISSUE;
					pending <= '1;
				end
			end
			ISSUE: begin
				pending <= pending & ~go;
				if ((pending & ~go) == '0) begin
					state <= ACK_WAIT;
				end
			end
			ACK_WAIT: begin
				if (!bundle_ack) begin
					bundle_ack <= 1'b1;
				end else if (!bundle_req) begin
					bundle_ack <= 1'b0;
					state <= IDLE;
				end
			end
			default: state <= IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (state == IDLE && bundle_req) begin
		slot_instr[0] <= bundle_instr0;
		slot_instr[1] <= bundle_instr1;
	end
	lane_op <= dec_op;
	lane_a <= opnd_a;
	lane_b <= opnd_b;
	lane_rd <= dec_rd;
end

endmodule

// File: logic/regfile.sv
`timescale 1ns/100ps

module regfile #(
	parameter int READ_PORTS = 4
) (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic [1:0]                               we,
	input  core_pkg::reg_addr_t [1:0]                waddr,
	input  core_pkg::word_t [1:0]                    wdata,
	input  core_pkg::reg_addr_t [READ_PORTS-1:0]     raddr,
	output core_pkg::word_t [READ_PORTS-1:0]         rdata
);

import core_pkg::*;

word_t regs [REG_NUM];

// port 1 is the younger slot, so it lands last
always_ff @(posedge clk) begin
	if (rst) begin
		for (int r = 0; r < REG_NUM; r++) begin
			regs[r] <= '0;
		end
	end else begin
		for (int w = 0; w < 2; w++) begin
			if (we[w] && waddr[w] != '0) begin
				regs[waddr[w]] <= wdata[w];
			end
		end
	end
end

// plain array read, bypass lives in the issue unit
always_comb begin
	for (int p = 0; p < READ_PORTS; p++) begin
		rdata[p] = regs[raddr[p]];
	end
end

endmodule

// File: logic/writeback_unit.sv
`timescale 1ns/100ps

module writeback_unit (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic [core_pkg::ISSUE_NUM-1:0]                res_valid,
	input  core_pkg::reg_addr_t [core_pkg::ISSUE_NUM-1:0] res_rd,
	input  core_pkg::word_t [core_pkg::ISSUE_NUM-1:0]     res_data,
	output logic [core_pkg::ISSUE_NUM-1:0]                we,
	output core_pkg::reg_addr_t [core_pkg::ISSUE_NUM-1:0] waddr,
	output core_pkg::word_t [core_pkg::ISSUE_NUM-1:0]     wdata,
	output core_pkg::word_t                               retire_count
);

import core_pkg::*;

word_t num_retired;

// an older lane loses to a younger one on the same register
always_comb begin
	for (int i = 0; i < ISSUE_NUM; i++) begin
		we[i] = res_valid[i];
		waddr[i] = res_rd[i];
		wdata[i] = res_data[i];
		for (int j = i + 1; j < ISSUE_NUM; j++) begin
			if (res_valid[j] && res_rd[j] == res_rd[i] && res_rd[i] != '0) begin
				we[i] = 1'b0;
			end
		end
	end
end

// every valid result retires, no-ops and suppressed writes too
always_comb begin
	num_retired = '0;
	for (int i = 0; i < ISSUE_NUM; i++) begin
		num_retired = num_retired + word_t'(res_valid[i]);
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		retire_count <= '0;
	end else begin
		retire_count <= retire_count + num_retired;
	end
end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module core_tb -f compile.f -o core_sim \
	&& ./obj_dir/core_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "^Test passed$" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

// File: test/core_tb.sv
`timescale 1ns/100ps

module core_tb;

import core_pkg::*;

logic clk;
logic rst;
logic bundle_req;
instr_t bundle_instr0;
instr_t bundle_instr1;
logic bundle_ack;
reg_addr_t dbg_addr;
word_t dbg_data;
word_t retire_count;

word_t model [REG_NUM];
int sent = 0;
int errors = 0;
int unsigned wait_limit = 100;
string cur_test = "reset";

core_top i_core_top (
	.clk,
	.rst,
	.bundle_req,
	.bundle_instr0,
	.bundle_instr1,
	.bundle_ack,
	.dbg_addr,
	.dbg_data,
	.retire_count
);

initial begin
	clk = 1'b0;
	forever begin
		#20 clk = ~clk;
	end
end

function automatic instr_t enc_r(input logic [5:0] fn, input reg_addr_t rd,
		input reg_addr_t rs, input reg_addr_t rt, input logic [4:0] sa);
	return {OPC_SPECIAL, rs, rt, rd, sa, fn};
endfunction

function automatic instr_t enc_i(input logic [5:0] opc, input reg_addr_t rt,
		input reg_addr_t rs, input logic [15:0] imm);
	return {opc, rs, rt, imm};
endfunction

// reference behavior of one instruction in program order
task automatic model_step(input instr_t ins);
	word_t rs_val;
	word_t rt_val;
	word_t res;
	reg_addr_t dst;
	rs_val = model[ins[25:21]];
	rt_val = model[ins[20:16]];
	res = '0;
	dst = '0;
	case (ins[31:26])
		OPC_SPECIAL: begin
			dst = ins[15:11];
			case (ins[5:0])
				FN_ADDU: res = rs_val + rt_val;
				FN_SUBU: res = rs_val - rt_val;
				FN_AND: res = rs_val & rt_val;
				FN_OR: res = rs_val | rt_val;
				FN_XOR: res = rs_val ^ rt_val;
				FN_SLT: res = ($signed(rs_val) < $signed(rt_val)) ? 32'd1 : 32'd0;
				FN_SLL: res = rt_val << ins[10:6];
				default: dst = '0;
			endcase
		end
		OPC_ADDIU: begin
			dst = ins[20:16];
			res = rs_val + {{16{ins[15]}}, ins[15:0]};
		end
		OPC_ORI: begin
			dst = ins[20:16];
			res = rs_val | {16'h0000, ins[15:0]};
		end
		OPC_LUI: begin
			dst = ins[20:16];
			res = {ins[15:0], 16'h0000};
		end
		default: dst = '0;
	endcase
	if (dst != '0) begin
		model[dst] = res;
	end
endtask

task automatic compare(input string name, input word_t exp, input word_t act);
	if (exp !== act) begin
		errors++;
		$display("** Error %s: expected %h, actual %h", name, exp, act);
	end
endtask

task automatic timed_out(input string what);
	$display("timeout while waiting for %s", what);
	$display("Test failed");
	$finish;
endtask

task automatic send_bundle(input instr_t i0, input instr_t i1);
	int unsigned cycles;
	cycles = 0;
	while (bundle_ack && cycles < wait_limit) begin
		@(negedge clk);
		cycles++;
	end
	compare($sformatf("%s ack low before req", cur_test), 32'd0, word_t'(bundle_ack));
	@(posedge clk);
	bundle_instr0 <= i0;
	bundle_instr1 <= i1;
	bundle_req <= 1'b1;
	cycles = 0;
	@(negedge clk);
	while (!bundle_ack && cycles < wait_limit) begin
		@(negedge clk);
		cycles++;
	end
	if (!bundle_ack) begin
		timed_out("bundle_ack to rise");
	end
	@(posedge clk);
	bundle_req <= 1'b0;
	cycles = 0;
	@(negedge clk);
	while (bundle_ack && cycles < wait_limit) begin
		@(negedge clk);
		cycles++;
	end
	if (bundle_ack) begin
		timed_out("bundle_ack to fall");
	end
	model_step(i0);
	model_step(i1);
	sent += 2;
endtask

task automatic drain();
	int unsigned cycles;
	cycles = 0;
	while (retire_count != word_t'(sent) && cycles < wait_limit) begin
		@(negedge clk);
		cycles++;
	end
	if (retire_count != word_t'(sent)) begin
		timed_out("retire_count to reach the number of sent instructions");
	end
endtask

task automatic check_regs(input string name);
	drain();
	for (int r = 0; r < REG_NUM; r++) begin
		@(posedge clk);
		dbg_addr <= 5'(r);
		@(negedge clk);
		compare($sformatf("%s r%0d", name, r), model[r], dbg_data);
	end
	compare($sformatf("%s retire_count", name), word_t'(sent), retire_count);
endtask

function automatic instr_t rand_instr();
	int unsigned pick;
	reg_addr_t rd;
	reg_addr_t rs;
	reg_addr_t rt;
	logic [15:0] imm;
	instr_t ins;
	pick = $urandom % 10;
	rd = 5'($urandom);
	rs = 5'($urandom);
	rt = 5'($urandom);
	imm = 16'($urandom);
	case (pick)
		0: ins = enc_r(FN_ADDU, rd, rs, rt, 5'd0);
		1: ins = enc_r(FN_SUBU, rd, rs, rt, 5'd0);
		2: ins = enc_r(FN_AND, rd, rs, rt, 5'd0);
		3: ins = enc_r(FN_OR, rd, rs, rt, 5'd0);
		4: ins = enc_r(FN_XOR, rd, rs, rt, 5'd0);
		5: ins = enc_r(FN_SLT, rd, rs, rt, 5'd0);
		// rs reused as the shift amount
		6: ins = enc_r(FN_SLL, rd, 5'd0, rt, rs);
		7: ins = enc_i(OPC_ADDIU, rt, rs, imm);
		8: ins = enc_i(OPC_ORI, rt, rs, imm);
		default: ins = enc_i(OPC_LUI, rt, 5'd0, imm);
	endcase
	return ins;
endfunction

task automatic op_coverage();
	cur_test = "ops";
	send_bundle(enc_i(OPC_ADDIU, 5'd1, 5'd0, 16'hfffb), enc_i(OPC_LUI, 5'd2, 5'd0, 16'h1234));
	send_bundle(enc_i(OPC_ORI, 5'd2, 5'd2, 16'h5678), enc_i(OPC_ADDIU, 5'd3, 5'd0, 16'd3));
	send_bundle(enc_r(FN_ADDU, 5'd4, 5'd1, 5'd2, 5'd0), enc_r(FN_SUBU, 5'd5, 5'd1, 5'd2, 5'd0));
	send_bundle(enc_r(FN_AND, 5'd6, 5'd1, 5'd2, 5'd0), enc_r(FN_OR, 5'd7, 5'd1, 5'd2, 5'd0));
	send_bundle(enc_r(FN_XOR, 5'd8, 5'd1, 5'd2, 5'd0), enc_r(FN_SLT, 5'd9, 5'd1, 5'd2, 5'd0));
	send_bundle(enc_r(FN_SLT, 5'd10, 5'd2, 5'd1, 5'd0),
		enc_r(FN_SLL, 5'd11, 5'd0, 5'd1, 5'd31));
	send_bundle(enc_r(FN_SLL, 5'd19, 5'd0, 5'd2, 5'd4),
		enc_r(FN_SUBU, 5'd20, 5'd0, 5'd3, 5'd0));
	check_regs("ops");
endtask

task automatic dependency_chains();
	cur_test = "intra dep";
	// slot 1 reads slot 0, so the bundle splits
	send_bundle(enc_i(OPC_ADDIU, 5'd12, 5'd0, 16'd7),
		enc_r(FN_ADDU, 5'd13, 5'd12, 5'd12, 5'd0));
	check_regs("intra dep");
	cur_test = "back to back";
	send_bundle(enc_i(OPC_ADDIU, 5'd14, 5'd0, 16'd100), enc_i(OPC_ADDIU, 5'd15, 5'd0, 16'd200));
	send_bundle(enc_r(FN_ADDU, 5'd16, 5'd14, 5'd15, 5'd0),
		enc_r(FN_SUBU, 5'd17, 5'd15, 5'd14, 5'd0));
	check_regs("back to back");
endtask

task automatic same_dest_writes();
	cur_test = "same dest";
	send_bundle(enc_i(OPC_ADDIU, 5'd18, 5'd0, 16'd1), enc_i(OPC_ADDIU, 5'd18, 5'd0, 16'd2));
	send_bundle(enc_r(FN_ADDU, 5'd21, 5'd1, 5'd1, 5'd0), enc_i(OPC_ORI, 5'd21, 5'd0, 16'hbeef));
	check_regs("same dest");
endtask

task automatic zero_and_unknown();
	cur_test = "r0 and unknown";
	send_bundle(enc_i(OPC_ADDIU, 5'd0, 5'd0, 16'd55), enc_r(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
	send_bundle(enc_i(6'h3f, 5'd2, 5'd1, 16'h1234), enc_r(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0));
	check_regs("r0 and unknown");
endtask

task automatic random_bundles();
	cur_test = "random";
	for (int n = 0; n < 200; n++) begin
		send_bundle(rand_instr(), rand_instr());
	end
	check_regs("random");
endtask

initial begin
	rst = 1'b1;
	bundle_req = 1'b0;
	bundle_instr0 = '0;
	bundle_instr1 = '0;
	dbg_addr = '0;
	for (int r = 0; r < REG_NUM; r++) begin
		model[r] = '0;
	end
	void'($urandom(70380));
	repeat (2) @(posedge clk);
	rst <= 1'b0;
	@(negedge clk);
	op_coverage();
	dependency_chains();
	same_dest_writes();
	zero_and_unknown();
	random_bundles();
	$display("checks done, %0d errors", errors);
	if (errors == 0) begin
		$display("Test passed");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule
